// File: wisc_decode.f
rtl/isa_pkg.sv
rtl/ctrl_pkg.sv
rtl/exec_decode.sv
rtl/wb_decode.sv
rtl/flow_decode.sv
rtl/decode_stage.sv
testbench/decode_stage_checker.sv
testbench/decode_stage_tb.sv

// File: Bender.yml
package:
  name: wisc_decode

sources:
  - rtl/isa_pkg.sv
  - rtl/ctrl_pkg.sv
  - rtl/exec_decode.sv
  - rtl/wb_decode.sv
  - rtl/flow_decode.sv
  - rtl/decode_stage.sv
  - target: simulation
    files:
      - testbench/decode_stage_checker.sv
      - testbench/decode_stage_tb.sv

// File: testbench/decode_stage_tb.sv
module decode_stage_tb
        import isa_pkg::*, ctrl_pkg::*;
();

        localparam int period       = 10;
        localparam int reset_cycles = 5;
        localparam int n_imm        = 88;      // 8 rounds of 11 opcodes
        localparam int n_rfmt       = 40;
        localparam int n_mem        = 56;      // 8 rounds of 7 opcodes
        localparam int n_flow       = 48;      // 4 rounds of 12 opcodes
        localparam int n_stream     = 400;
        localparam int n_tests      = 6;
        localparam int limit_cycles = reset_cycles + n_imm + n_rfmt + n_mem + n_flow + n_stream
                                      + 2 * n_tests + 100;

        logic   clk = 1'b0;
        logic   rst;
        logic   instr_valid;
        instr_t instr;
        logic   ctrl_valid;
        ctrl_t  ctrl;

        ctrl_t  exp_ctrl;                       // One-entry model pipeline
        logic   exp_valid;
        int     seed = 32'h88fbc499;
        int     checks = 0;
        int     errors = 0;
        int     test_base = 0;                  // Error count at test start
        logic [opcode_w-1:0] op_pool[$];        // Opcodes cycled through by a test

        decode_stage uut (
                .clk         (clk),
                .rst         (rst),
                .instr_valid (instr_valid),
                .instr       (instr),
                .ctrl_valid  (ctrl_valid),
                .ctrl        (ctrl)
        );

        bind decode_stage decode_stage_checker u_checker (.clk(clk), .rst(rst),
                .instr_valid(instr_valid), .ctrl_valid(ctrl_valid), .ctrl(ctrl));

        always #(period / 2) clk = ~clk;

        initial begin                           // Watchdog
                #(limit_cycles * period);
                $display("Timeout: run did not finish within %0d cycles", limit_cycles);
                $display("Simulation finished: FAIL");
                $finish;
        end

        // Expected bundle straight from the decode rules
        function automatic ctrl_t model_ctrl(input instr_t i);
                ctrl_t               c;
                logic [opcode_w-1:0] op;
                logic [funct_w-1:0]  fn;
                logic                imm_alu;
                logic                branch;
                op      = i.r_fmt.opcode;
                fn      = i.r_fmt.funct;
                imm_alu = (op == op_addi) || (op == op_subi) || (op == op_xori)
                          || (op == op_andni) || (op == op_roli) || (op == op_slli)
                          || (op == op_rori) || (op == op_srli);
                branch  = (op == op_beqz) || (op == op_bnez) || (op == op_bltz) || (op == op_bgez);
                c = '0;                         // All codes 0 except flow defaults
                c.flow.branch_type = br_none;
                c.flow.pc_sel      = pc_next;
                case (op)
                        op_xori:    c.exec.alu_op = 4'b0010;
                        op_andni:   c.exec.alu_op = 4'b0011;
                        op_roli:    c.exec.alu_op = 4'b0100;
                        op_slli:    c.exec.alu_op = 4'b0101;
                        op_rori:    c.exec.alu_op = 4'b0110;
                        op_srli:    c.exec.alu_op = 4'b0111;
                        op_btr:     c.exec.alu_op = 4'b1000;
                        op_lbi:     c.exec.alu_op = 4'b1001;
                        op_slbi:    c.exec.alu_op = 4'b0101;
                        op_alu_r:   c.exec.alu_op = {2'b00, fn};
                        op_shift_r: c.exec.alu_op = {2'b01, fn};
                        default:    c.exec.alu_op = 4'b0000;
                endcase
                c.exec.inv_a   = (op == op_subi) || (op == op_alu_r && fn == 2'b01);
                c.exec.alu_cin = (op == op_alu_r && fn == 2'b01) || (op == op_slt)
                                 || (op == op_sle) || (op == op_bltz) || (op == op_bgez);
                c.exec.inv_b   = c.exec.alu_cin && (op != op_alu_r)   // Compare group
                                 || (op == op_alu_r && fn == 2'b11) || (op == op_andni);
                case (op)
                        op_addi, op_subi, op_st, op_ld, op_stu, op_alu_r, op_seq, op_slt,
                        op_sle, op_sco, op_bltz: c.exec.sign = 1'b1;
                        default: c.exec.sign = 1'b0;
                endcase
                if (imm_alu || op == op_st || op == op_ld || op == op_stu || op == op_lbi
                    || op == op_jr || op == op_jalr) c.exec.alu_src = alu_src_imm;
                else if (branch) c.exec.alu_src = alu_src_zero;
                else if (op == op_slbi) c.exec.alu_src = alu_src_slbi;
                case (op)
                        op_addi, op_subi, op_st, op_ld, op_stu, op_seq, op_slt, op_sle, op_lbi,
                        op_j, op_jr, op_jal, op_jalr: c.exec.sign_ext = 1'b1;
                        default: c.exec.sign_ext = branch;
                endcase
                if (branch || op == op_lbi || op == op_slbi || op == op_jr || op == op_jalr)
                        c.exec.imm_sel = imm_8;
                else if (op == op_j || op == op_jal) c.exec.imm_sel = imm_11;
                c.wb.wr_en = imm_alu || (op[4:3] == 2'b10 && op != op_st) || (op[4:3] == 2'b11)
                             || (op == op_jal) || (op == op_jalr);
                case (op)
                        op_btr, op_alu_r, op_shift_r: c.wb.reg_dst = dst_rd_r;
                        op_seq, op_slt, op_sle, op_sco: begin
                                c.wb.reg_dst = dst_rd_r;
                                c.wb.res_sel = res_set;
                        end
                        op_stu, op_lbi: c.wb.reg_dst = dst_rs;
                        op_slbi: begin
                                c.wb.reg_dst = dst_rs;
                                c.wb.res_sel = res_slbi;
                        end
                        op_jal, op_jalr: begin
                                c.wb.reg_dst = dst_r7;
                                c.wb.res_sel = res_link;
                        end
                        default: ;
                endcase
                if (op == op_seq) c.wb.set_op = set_eq;
                if (op == op_slt) c.wb.set_op = set_lt;
                if (op == op_sle) c.wb.set_op = set_le;
                c.wb.mem_wr     = (op == op_st) || (op == op_stu);
                c.wb.mem_en     = (op == op_st) || (op == op_ld) || (op == op_stu);
                c.wb.mem_to_reg = (op == op_ld);
                case (op)
                        op_halt: c.flow = '{branch_type: br_eqz, pc_sel: pc_hold, halt: 1'b1};
                        op_beqz: c.flow.branch_type = br_eqz;
                        op_bnez: c.flow.branch_type = br_nez;
                        op_bltz: c.flow.branch_type = br_ltz;
                        op_bgez: c.flow.branch_type = br_gez;
                        op_j, op_jal: c.flow.branch_type = br_jump;
                        op_jr, op_jalr: c.flow = '{branch_type: br_jump, pc_sel: pc_reg, halt: 1'b0};
                        default: ;              // NOP and the two reserved codes
                endcase
                return c;
        endfunction

        task automatic check_exec(input exec_ctrl_t exp, input exec_ctrl_t act);
                checks++;
                if (act !== exp) begin
                        errors++;
                        $display("MISMATCH at %0t: exec expected %h, got %h", $time, exp, act);
                end
        endtask

        task automatic check_wb(input wb_ctrl_t exp, input wb_ctrl_t act);
                checks++;
                if (act !== exp) begin
                        errors++;
                        $display("MISMATCH at %0t: wb expected %h, got %h", $time, exp, act);
                end
        endtask

        task automatic check_flow(input flow_ctrl_t exp, input flow_ctrl_t act);
                checks++;
                if (act !== exp) begin
                        errors++;
                        $display("MISMATCH at %0t: flow expected %h, got %h", $time, exp, act);
                end
        endtask

        task automatic check_valid(input logic exp, input logic act);
                checks++;
                if (act !== exp) begin
                        errors++;
                        $display("MISMATCH at %0t: ctrl_valid expected %b, got %b",
                                 $time, exp, act);
                end
        endtask

        task automatic compare_outputs();
                check_valid(exp_valid, ctrl_valid);
                check_exec(exp_ctrl.exec, ctrl.exec);
                check_wb(exp_ctrl.wb, ctrl.wb);
                check_flow(exp_ctrl.flow, ctrl.flow);
        endtask

        // Check the last result and drive the next input on the falling edge
        task automatic apply(input logic v, input instr_t i);
                @(negedge clk);
                compare_outputs();
                instr_valid = v;
                instr       = i;
                exp_valid   = v;
                if (v) exp_ctrl = model_ctrl(i);        // Gap keeps the old bundle
        endtask

        function automatic instr_t random_word();
                logic [31:0] r;
                r = $random(seed);
                return r[instr_w-1:0];
        endfunction

        task automatic run_pool(input int count);
                instr_t i;
                for (int k = 0; k < count; k++) begin
                        i = random_word();              // Random register and funct fields
                        i.r_fmt.opcode = op_pool[k % op_pool.size()];
                        apply(1'b1, i);
                end
        endtask

        task automatic end_test(input string name);
                apply(1'b0, random_word());             // Flush the last instruction
                $display("[%0t] %s done, %0d mismatches", $time, name, errors - test_base);
                test_base = errors;
        endtask

        initial begin
                int total;
                rst         = 1'b1;
                instr_valid = 1'b0;
                instr       = '0;
                repeat (reset_cycles) @(posedge clk);
                @(negedge clk);
                rst       = 1'b0;
                exp_valid = 1'b0;
                exp_ctrl  = ctrl_nop;
                compare_outputs();
                end_test("reset");

                op_pool = '{op_addi, op_subi, op_xori, op_andni, op_roli, op_slli, op_rori,
                            op_srli, op_lbi, op_slbi, op_btr};
                run_pool(n_imm);
                end_test("immediate alu and shift");

                op_pool = '{op_alu_r, op_shift_r};
                run_pool(n_rfmt);
                end_test("r-format groups");

                op_pool = '{op_st, op_ld, op_stu, op_seq, op_slt, op_sle, op_sco};
                run_pool(n_mem);
                end_test("memory and set");

                op_pool = '{op_halt, op_beqz, op_bnez, op_bltz, op_bgez, op_j, op_jr, op_jal,
                            op_jalr, op_nop, 5'b00010, 5'b00011};
                run_pool(n_flow);
                end_test("flow control");

                for (int k = 0; k < n_stream; k++)
                        apply(({$random(seed)} % 4) != 0, random_word());  // About 1 in 4 is a gap
                end_test("random stream");

                total = errors + uut.u_checker.assert_errors;
                $display("tests %0d, checks %0d, mismatches %0d, assertion failures %0d",
                         n_tests, checks, errors, uut.u_checker.assert_errors);
                if (total == 0) begin
                        $display("Simulation finished: PASS");
                end else begin
                        $display("Simulation finished: FAIL");
                end
                $finish;
        end

endmodule

// File: testbench/decode_stage_checker.sv
module decode_stage_checker
        import isa_pkg::*, ctrl_pkg::*;
(
        input logic   clk,
        input logic   rst,
        input logic   instr_valid,
        input logic   ctrl_valid,
        input ctrl_t  ctrl
);

        int assert_errors = 0;                  // Failed assertions so far

        a_reset_clears_valid: assert property (@(posedge clk) rst |=> !ctrl_valid)
                else begin
                        $error("ctrl_valid high after reset");
                        assert_errors++;
                end

        a_valid_follows: assert property (@(posedge clk)
                !rst |=> (ctrl_valid == $past(instr_valid)))
                else begin
                        $error("ctrl_valid does not follow instr_valid");
                        assert_errors++;
                end

        a_halt_quiet: assert property (@(posedge clk)
                ctrl.flow.halt |-> (!ctrl.wb.wr_en && !ctrl.wb.mem_wr))
                else begin
                        $error("halt with a register or memory write");
                        assert_errors++;
                end

        a_store_enabled: assert property (@(posedge clk) ctrl.wb.mem_wr |-> ctrl.wb.mem_en)
                else begin
                        $error("memory write without memory enable");
                        assert_errors++;
                end

endmodule

// File: rtl/decode_stage.sv
module decode_stage
        import isa_pkg::*, ctrl_pkg::*;
(
        input  logic   clk,
        input  logic   rst,
        input  logic   instr_valid,
        input  instr_t instr,
        output logic   ctrl_valid,
        output ctrl_t  ctrl
);

        exec_ctrl_t exec_next;
        wb_ctrl_t   wb_next;
        flow_ctrl_t flow_next;
        ctrl_t      ctrl_next;

        exec_decode u_exec_decode (
                .instr (instr),
                .exec  (exec_next)                  // ALU and immediate
        );

        wb_decode u_wb_decode (
                .instr (instr),
                .wb    (wb_next)                    // Register file and memory
        );

        flow_decode u_flow_decode (
                .instr (instr),
                .flow  (flow_next)                  // Branch, PC, halt
        );

        assign ctrl_next = '{exec: exec_next, wb: wb_next, flow: flow_next};

        // Decode to execute boundary
        always_ff @(posedge clk) begin
                if (rst) begin
                        ctrl_valid <= 1'b0;
                        ctrl       <= ctrl_nop;      // Safe bundle out of reset
                end else begin
                        ctrl_valid <= instr_valid;   // One cycle behind the input
                        if (instr_valid) begin
                                ctrl <= ctrl_next;
                        end                          // Hold last bundle on a gap
                end
        end

endmodule

// File: rtl/flow_decode.sv
module flow_decode
        import isa_pkg::*, ctrl_pkg::*;
(
        input  instr_t     instr,
        output flow_ctrl_t flow
);

        logic [opcode_w-1:0] op;

        assign op = instr.i_fmt.opcode;

        always_comb begin
                flow = ctrl_nop.flow;               // Fall through to next PC
                case (op)
                        op_halt: begin
                                flow.branch_type = br_eqz;         // Halt shares the BEQZ code
                                flow.pc_sel      = pc_hold;        // PC frozen on halt
                                flow.halt        = 1'b1;
                        end
                        op_beqz: flow.branch_type = br_eqz;
                        op_bnez: flow.branch_type = br_nez;
                        op_bltz: flow.branch_type = br_ltz;
                        op_bgez: flow.branch_type = br_gez;
                        op_j, op_jal: flow.branch_type = br_jump;  // PC plus displacement
                        op_jr, op_jalr: begin
                                flow.branch_type = br_jump;
                                flow.pc_sel      = pc_reg;         // Target from ALU result
                        end
                        default: ;                                 // NOP, 00010 and 00011
                endcase
        end

endmodule

// File: rtl/wb_decode.sv
module wb_decode
        import isa_pkg::*, ctrl_pkg::*;
(
        input  instr_t   instr,
        output wb_ctrl_t wb
);

        logic [opcode_w-1:0] op;

        assign op = instr.i_fmt.opcode;             // Same bits in both formats

        always_comb begin
                wb         = '0;                    // No write, no memory access
                wb.reg_dst = dst_rd_i;
                wb.res_sel = res_alu;
                wb.set_op  = set_none;

                // Register write by opcode group
                case (op[opcode_w-1 -: 2])
                        2'b01:   wb.wr_en = ~op[2];                // 010xx ALU imm, 011xx branch
                        2'b10:   wb.wr_en = (op != op_st);         // Stores write nothing back
                        2'b11:   wb.wr_en = 1'b1;                  // R-format, set, LBI, BTR
                        default: wb.wr_en = (op == op_jal) || (op == op_jalr);
                endcase

                case (op)
                        op_btr, op_alu_r, op_shift_r: wb.reg_dst = dst_rd_r;
                        op_seq: begin
                                wb.reg_dst = dst_rd_r;
                                wb.res_sel = res_set;
                                wb.set_op  = set_eq;
                        end
                        op_slt: begin
                                wb.reg_dst = dst_rd_r;
                                wb.res_sel = res_set;
                                wb.set_op  = set_lt;
                        end
                        op_sle: begin
                                wb.reg_dst = dst_rd_r;
                                wb.res_sel = res_set;
                                wb.set_op  = set_le;
                        end
                        op_sco: begin
                                wb.reg_dst = dst_rd_r;
                                wb.res_sel = res_set;              // Flag taken from carry out
                        end
                        op_st: begin
                                wb.mem_wr = 1'b1;
                                wb.mem_en = 1'b1;
                        end
                        op_ld: begin
                                wb.mem_en     = 1'b1;
                                wb.mem_to_reg = 1'b1;
                        end
                        op_stu: begin
                                wb.reg_dst = dst_rs;               // Base register updated
                                wb.mem_wr  = 1'b1;
                                wb.mem_en  = 1'b1;
                        end
                        op_lbi:  wb.reg_dst = dst_rs;
                        op_slbi: begin
                                wb.reg_dst = dst_rs;
                                wb.res_sel = res_slbi;
                        end
                        op_jal, op_jalr: begin
                                wb.reg_dst = dst_r7;               // Return address into r7
                                wb.res_sel = res_link;
                        end
                        default: ;
                endcase
        end

endmodule

// File: rtl/exec_decode.sv
module exec_decode
        import isa_pkg::*, ctrl_pkg::*;
(
        input  instr_t     instr,
        output exec_ctrl_t exec
);

        logic [opcode_w-1:0] op;
        logic [funct_w-1:0]  funct;

        assign op    = instr.r_fmt.opcode;
        assign funct = instr.r_fmt.funct;          // Only meaningful for R groups

        always_comb begin
                exec         = '0;                 // Plain add, no inversion
                exec.alu_src = alu_src_reg;
                exec.imm_sel = imm_5;
                case (op)
                        op_addi: begin
                                exec.alu_src  = alu_src_imm;
                                exec.sign     = 1'b1;
                                exec.sign_ext = 1'b1;
                        end
                        op_subi: begin
                                exec.inv_a    = 1'b1;        // imm minus rs
                                exec.alu_src  = alu_src_imm;
                                exec.sign     = 1'b1;
                                exec.sign_ext = 1'b1;
                        end
                        op_xori: begin
                                exec.alu_op  = {2'b00, op[1:0]};   // 0010
                                exec.alu_src = alu_src_imm;        // Zero extended
                        end
                        op_andni: begin
                                exec.alu_op  = {2'b00, op[1:0]};   // 0011
                                exec.inv_b   = 1'b1;               // AND with ~imm
                                exec.alu_src = alu_src_imm;
                        end
                        op_roli, op_slli, op_rori, op_srli: begin
                                exec.alu_op  = {2'b01, op[1:0]};   // Low bits pick the shift
                                exec.alu_src = alu_src_imm;
                        end
                        op_st, op_ld, op_stu: begin
                                exec.alu_src  = alu_src_imm;       // Address rs plus offset
                                exec.sign     = 1'b1;
                                exec.sign_ext = 1'b1;
                        end
                        op_btr: exec.alu_op = 4'b1000;             // Bit reverse of rs
                        op_lbi: begin
                                exec.alu_op   = 4'b1001;           // Pass operand B
                                exec.alu_src  = alu_src_imm;
                                exec.sign_ext = 1'b1;
                                exec.imm_sel  = imm_8;
                        end
                        op_slbi: begin
                                exec.alu_op  = 4'b0101;            // rs shifted left by 8
                                exec.alu_src = alu_src_slbi;
                                exec.imm_sel = imm_8;
                        end
                        op_alu_r: begin
                                exec.alu_op  = {2'b00, funct};
                                exec.inv_a   = (funct == 2'b01);   // SUB is rt minus rs
                                exec.alu_cin = (funct == 2'b01);
                                exec.inv_b   = (funct == 2'b11);   // ANDN
                                exec.sign    = 1'b1;
                        end
                        op_shift_r: exec.alu_op = {2'b01, funct};
                        op_seq: begin
                                exec.sign     = 1'b1;
                                exec.sign_ext = 1'b1;
                        end
                        op_slt, op_sle: begin
                                exec.inv_b    = 1'b1;              // rs minus rt for compare
                                exec.alu_cin  = 1'b1;
                                exec.sign     = 1'b1;
                                exec.sign_ext = 1'b1;
                        end
                        op_sco: exec.sign = 1'b1;                  // Carry out of rs plus rt
                        op_beqz, op_bnez, op_bltz, op_bgez: begin
                                exec.inv_b    = (op == op_bltz) || (op == op_bgez);
                                exec.alu_cin  = (op == op_bltz) || (op == op_bgez);
                                exec.sign     = (op == op_bltz);
                                exec.alu_src  = alu_src_zero;      // Compare rs against 0
                                exec.sign_ext = 1'b1;
                                exec.imm_sel  = imm_8;
                        end
                        op_j, op_jal: begin
                                exec.sign_ext = 1'b1;
                                exec.imm_sel  = imm_11;            // PC relative displacement
                        end
                        op_jr, op_jalr: begin
                                exec.alu_src  = alu_src_imm;       // Target rs plus imm
                                exec.sign_ext = 1'b1;
                                exec.imm_sel  = imm_8;
                        end
                        default: ;                                 // HALT, NOP, reserved codes
                endcase
        end

endmodule

// File: rtl/ctrl_pkg.sv
package ctrl_pkg;

        localparam int alu_op_w = 4;            // ALU operation select

        // Second ALU operand
        localparam logic [1:0] alu_src_reg  = 2'b00;   // Register rt
        localparam logic [1:0] alu_src_imm  = 2'b01;   // Extended immediate
        localparam logic [1:0] alu_src_slbi = 2'b10;   // Immediate for shift-and-load
        localparam logic [1:0] alu_src_zero = 2'b11;   // Constant zero for branch compare

        // Immediate length before extension
        localparam logic [1:0] imm_5  = 2'b00;
        localparam logic [1:0] imm_8  = 2'b01;
        localparam logic [1:0] imm_11 = 2'b10;

        // Destination register field
        localparam logic [1:0] dst_rd_i = 2'b00;       // rd of I-format
        localparam logic [1:0] dst_rd_r = 2'b01;       // rd of R-format
        localparam logic [1:0] dst_rs   = 2'b10;
        localparam logic [1:0] dst_r7   = 2'b11;       // Link register

        // Writeback result source
        localparam logic [1:0] res_alu  = 2'b00;
        localparam logic [1:0] res_link = 2'b01;       // PC plus two
        localparam logic [1:0] res_set  = 2'b10;       // Compare flag
        localparam logic [1:0] res_slbi = 2'b11;

        // Set compare kind
        localparam logic [1:0] set_none = 2'b00;
        localparam logic [1:0] set_le   = 2'b01;
        localparam logic [1:0] set_lt   = 2'b10;
        localparam logic [1:0] set_eq   = 2'b11;

        // Branch condition
        localparam logic [2:0] br_eqz  = 3'b000;
        localparam logic [2:0] br_nez  = 3'b001;
        localparam logic [2:0] br_ltz  = 3'b010;
        localparam logic [2:0] br_gez  = 3'b011;
        localparam logic [2:0] br_jump = 3'b100;       // Unconditional
        localparam logic [2:0] br_none = 3'b111;

        // Next PC source
        localparam logic [1:0] pc_reg  = 2'b00;        // Register plus offset
        localparam logic [1:0] pc_next = 2'b01;
        localparam logic [1:0] pc_hold = 2'b10;

        typedef struct packed {
                logic [alu_op_w-1:0] alu_op;
                logic                inv_a;
                logic                inv_b;
                logic                alu_cin;
                logic                sign;       // Signed overflow rules
                logic [1:0]          alu_src;
                logic                sign_ext;
                logic [1:0]          imm_sel;
        } exec_ctrl_t;

        typedef struct packed {
                logic [1:0] reg_dst;
                logic       wr_en;
                logic [1:0] res_sel;
                logic [1:0] set_op;
                logic       mem_wr;
                logic       mem_en;
                logic       mem_to_reg;         // Load data instead of result
        } wb_ctrl_t;

        typedef struct packed {
                logic [2:0] branch_type;
                logic [1:0] pc_sel;
                logic       halt;
        } flow_ctrl_t;

        typedef struct packed {
                exec_ctrl_t exec;
                wb_ctrl_t   wb;
                flow_ctrl_t flow;
        } ctrl_t;

        localparam ctrl_t ctrl_nop = '{
                exec: '{alu_op: '0, inv_a: 1'b0, inv_b: 1'b0, alu_cin: 1'b0, sign: 1'b0,
                        alu_src: alu_src_reg, sign_ext: 1'b0, imm_sel: imm_5},
                wb:   '{reg_dst: dst_rd_i, wr_en: 1'b0, res_sel: res_alu, set_op: set_none,
                        mem_wr: 1'b0, mem_en: 1'b0, mem_to_reg: 1'b0},
                flow: '{branch_type: br_none, pc_sel: pc_next, halt: 1'b0}
        };

endpackage

// File: rtl/isa_pkg.sv
package isa_pkg;

        localparam int instr_w  = 16;           // Full instruction word
        localparam int opcode_w = 5;            // Major opcode in the top bits
        localparam int funct_w  = 2;            // R-format function field
        localparam int reg_w    = 3;            // Eight registers
        localparam int imm_w    = instr_w - opcode_w - 2 * reg_w;  // Short immediate of 5 bits

        // Major opcodes
        localparam logic [opcode_w-1:0] op_halt    = 5'b00000;
        localparam logic [opcode_w-1:0] op_nop     = 5'b00001;
        localparam logic [opcode_w-1:0] op_j       = 5'b00100;
        localparam logic [opcode_w-1:0] op_jr      = 5'b00101;
        localparam logic [opcode_w-1:0] op_jal     = 5'b00110;
        localparam logic [opcode_w-1:0] op_jalr    = 5'b00111;
        localparam logic [opcode_w-1:0] op_addi    = 5'b01000;
        localparam logic [opcode_w-1:0] op_subi    = 5'b01001;
        localparam logic [opcode_w-1:0] op_xori    = 5'b01010;
        localparam logic [opcode_w-1:0] op_andni   = 5'b01011;
        localparam logic [opcode_w-1:0] op_beqz    = 5'b01100;
        localparam logic [opcode_w-1:0] op_bnez    = 5'b01101;
        localparam logic [opcode_w-1:0] op_bltz    = 5'b01110;
        localparam logic [opcode_w-1:0] op_bgez    = 5'b01111;
        localparam logic [opcode_w-1:0] op_st      = 5'b10000;
        localparam logic [opcode_w-1:0] op_ld      = 5'b10001;
        localparam logic [opcode_w-1:0] op_slbi    = 5'b10010;
        localparam logic [opcode_w-1:0] op_stu     = 5'b10011;
        localparam logic [opcode_w-1:0] op_roli    = 5'b10100;
        localparam logic [opcode_w-1:0] op_slli    = 5'b10101;
        localparam logic [opcode_w-1:0] op_rori    = 5'b10110;
        localparam logic [opcode_w-1:0] op_srli    = 5'b10111;
        localparam logic [opcode_w-1:0] op_lbi     = 5'b11000;
        localparam logic [opcode_w-1:0] op_btr     = 5'b11001;
        localparam logic [opcode_w-1:0] op_shift_r = 5'b11010;  // ROL SLL ROR SRL by funct
        localparam logic [opcode_w-1:0] op_alu_r   = 5'b11011;  // ADD SUB XOR ANDN by funct
        localparam logic [opcode_w-1:0] op_seq     = 5'b11100;
        localparam logic [opcode_w-1:0] op_slt     = 5'b11101;
        localparam logic [opcode_w-1:0] op_sle     = 5'b11110;
        localparam logic [opcode_w-1:0] op_sco     = 5'b11111;

        typedef struct packed {
                logic [opcode_w-1:0] opcode;
                logic [reg_w-1:0]    rs;         // First source
                logic [reg_w-1:0]    rt;         // Second source
                logic [reg_w-1:0]    rd;         // Destination
                logic [funct_w-1:0]  funct;      // Sub-operation
        } r_fmt_t;

        typedef struct packed {
                logic [opcode_w-1:0] opcode;
                logic [reg_w-1:0]    rs;
                logic [reg_w-1:0]    rd;         // Sits where rt is in R-format
                logic [imm_w-1:0]    imm;
        } i_fmt_t;

        typedef union packed {
                r_fmt_t r_fmt;
                i_fmt_t i_fmt;
        } instr_t;

endpackage
